// File: logic/uartRxPkg.sv
// Shared types for the UART receive path
// Data width is fixed at 8 bits, so the byte is a type and not a parameter
// Frames are 8N1 only, with no parity and one stop bit
// All users refer to these by scoped name

package uartRxPkg;

        ////////////////////
        // Data
        ////////////////////

        typedef logic [7:0] rxByte;                     // One received byte, LSB arrives first

        ////////////////////
        // Receiver FSM
        ////////////////////

        typedef enum logic [1:0] {
                idle,                                   // Line high, waiting for a falling edge
                start,                                  // Confirming the start bit at mid-bit
                data,                                   // Shifting eight data bits
                stop                                    // Judging the stop bit
        } rxState;

        ////////////////////
        // FIFO status
        ////////////////////

        typedef struct packed {
                logic empty;                            // No entry stored
                logic halfFull;                         // Count at least half the depth
                logic overflow;                         // Byte dropped since the last pop
                logic frameErr;                         // Low stop bit seen since reset
        } rxStatus;

endpackage

// File: logic/rxBitTimer.sv
// Oversampling bit timer for the UART receiver
// clksPerBit must be even and at least 4 so mid-bit and bit end never meet
// Counter is held at zero by timerRestart and only advances with timerRun
// Both outputs are decoded from the count and are low while stopped

`timescale 1ns/10ps

module rxBitTimer #(
        parameter int clksPerBit = 16
) (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic timerRun,
        input  logic timerRestart,
        output logic midBit,
        output logic bitEnd
);

        localparam int cntW = $clog2(clksPerBit);
        localparam logic [cntW-1:0] midCount  = cntW'(clksPerBit / 2);
        localparam logic [cntW-1:0] lastCount = cntW'(clksPerBit - 1);

        logic [cntW-1:0] bitCount;                      // Clocks into the current bit

        ////////////////////
        // Counter
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        bitCount <= '0;
                end else if (timerRestart) begin
                        bitCount <= '0;                 // Align to the start edge
                end else if (timerRun) begin
                        if (bitEnd)
                                bitCount <= '0;         // Wrap into the next bit
                        else
                                bitCount <= bitCount + 1'b1;
                end
        end

        // Sample points
        assign midBit = timerRun && (bitCount == midCount);     // Centre of the bit
        assign bitEnd = timerRun && (bitCount == lastCount);    // Last clock of the bit

        // Catches a bad clksPerBit reaching this block
        aMidNotEnd: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                !(midBit && bitEnd));

endmodule

// File: logic/rxControl.sv
// Receive FSM for one 8N1 frame
// Start is detected on the first low synchronized sample
// A start bit found high at mid-bit counts as a glitch and is ignored
// byteValid or frameErrSet pulse for one clock after the stop mid-bit
// No handshake back from the FIFO, the serial line cannot wait

`timescale 1ns/10ps

module rxControl (
        input  logic Data_Rdy,
        input  logic Pop_Data,
        input  logic sampledBit,
        input  logic midBit,
        output logic timerRun,
        output logic timerRestart,
        output logic shiftEn,
        output logic byteValid,
        output logic frameErrSet
);

        uartRxPkg::rxState state;                       // Current frame phase
        logic [2:0]        bitIdx;                      // Data bit being received

        ////////////////////
        // State register
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        state       <= uartRxPkg::idle;
                        bitIdx      <= '0;
                        byteValid   <= 1'b0;
                        frameErrSet <= 1'b0;
                end else begin
                        byteValid   <= 1'b0;            // Pulses only
                        frameErrSet <= 1'b0;
                        case (state)
                                uartRxPkg::idle: begin
                                        if (!sampledBit)
                                                state <= uartRxPkg::start;      // Falling edge seen
                                end
                                uartRxPkg::start: begin
                                        if (midBit) begin
                                                if (sampledBit) begin
                                                        state <= uartRxPkg::idle;   // Glitch
                                                end else begin
                                                        state  <= uartRxPkg::data;
                                                        bitIdx <= '0;
                                                end
                                        end
                                end
                                uartRxPkg::data: begin
                                        if (midBit) begin
                                                bitIdx <= bitIdx + 1'b1;
                                                if (bitIdx == 3'd7)
                                                        state <= uartRxPkg::stop;  // Eighth bit taken
                                        end
                                end
                                uartRxPkg::stop: begin
                                        if (midBit) begin
                                                byteValid   <= sampledBit;      // Good frame
                                                frameErrSet <= !sampledBit;     // Stop bit low
                                                state       <= uartRxPkg::idle;
                                        end
                                end
                                default: state <= uartRxPkg::idle;
                        endcase
                end
        end

        // Timer is parked at zero while idle so a start edge restarts it cleanly
        assign timerRun     = (state != uartRxPkg::idle);
        assign timerRestart = (state == uartRxPkg::idle);
        assign shiftEn      = (state == uartRxPkg::data) && midBit;    // One shift per data bit

        // A frame ends in exactly one of the two results
        aOneResult: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                !(byteValid && frameErrSet));

endmodule

// File: logic/rxShifter.sv
// Input synchronizer and serial-to-parallel register
// rxLine is asynchronous and reaches sampledBit two clocks late
// Synchronizer resets to the idle-high line level
// shiftData is only meaningful once a whole frame has been shifted

`timescale 1ns/10ps

module rxShifter (
        input  logic             Data_Rdy,
        input  logic             Pop_Data,
        input  logic             rxLine,
        input  logic             shiftEn,
        output logic             sampledBit,
        output uartRxPkg::rxByte shiftData
);

        logic syncMeta;                                 // First flop, may go metastable

        ////////////////////
        // Synchronizer
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        syncMeta   <= 1'b1;             // Idle line is high
                        sampledBit <= 1'b1;
                end else begin
                        syncMeta   <= rxLine;
                        sampledBit <= syncMeta;         // Safe to use from here on
                end
        end

        ////////////////////
        // Shift register
        ////////////////////

        // LSB arrives first, so bits enter at the top and move down
        always_ff @(posedge Data_Rdy) begin
                if (shiftEn)
                        shiftData <= {sampledBit, shiftData[7:1]};
        end

endmodule

// File: logic/rxFifo.sv
// Circular byte buffer with show-ahead output
// Depth is 2**fifoDepthLog2 entries, fifoDepthLog2 at least 2
// hold freezes the buffer, so no write and no pop is done while it is set
// A byte that cannot be stored is dropped and sets overflow until the next pop
// frameErr is sticky until reset
// A write while full is taken only when a pop frees the slot on the same clock

`timescale 1ns/10ps

module rxFifo #(
        parameter int fifoDepthLog2 = 3
) (
        input  logic               Data_Rdy,
        input  logic               Pop_Data,
        input  logic               wrValid,
        input  uartRxPkg::rxByte   wrData,
        input  logic               frameErrSet,
        input  logic               hold,
        input  logic               outReady,
        output logic               outValid,
        output uartRxPkg::rxByte   outData,
        output uartRxPkg::rxStatus status
);

        localparam int depth = 2 ** fifoDepthLog2;
        localparam logic [fifoDepthLog2:0] fullCount = (fifoDepthLog2 + 1)'(depth);
        localparam logic [fifoDepthLog2:0] halfCount = (fifoDepthLog2 + 1)'(depth / 2);

        uartRxPkg::rxByte         mem [depth];          // Byte storage
        logic [fifoDepthLog2-1:0] rdPtr;                // Oldest entry
        logic [fifoDepthLog2-1:0] wrPtr;                // Next free slot
        logic [fifoDepthLog2:0]   count;                // Entries stored
        logic                     overflowQ;
        logic                     frameErrQ;
        logic                     doPop;
        logic                     doWrite;
        logic                     dropped;

        ////////////////////
        // Write and pop decode
        ////////////////////

        assign outValid = (count != '0) && !hold;       // Nothing offered during hold
        assign doPop    = outValid && outReady;
        assign doWrite  = wrValid && !hold && ((count != fullCount) || doPop);
        assign dropped  = wrValid && !doWrite;          // Full or held

        always_ff @(posedge Data_Rdy) begin
                if (doWrite)
                        mem[wrPtr] <= wrData;
        end

        ////////////////////
        // Pointers and flags
        ////////////////////

        always_ff @(posedge Data_Rdy or posedge Pop_Data) begin
                if (Pop_Data) begin
                        rdPtr     <= '0;
                        wrPtr     <= '0;
                        count     <= '0;
                        overflowQ <= 1'b0;
                        frameErrQ <= 1'b0;
                end else begin
                        if (doWrite)
                                wrPtr <= wrPtr + 1'b1;  // Wraps with the pointer width
                        if (doPop)
                                rdPtr <= rdPtr + 1'b1;
                        case ({doWrite, doPop})
                                2'b10:   count <= count + 1'b1;
                                2'b01:   count <= count - 1'b1;
                                default: count <= count;        // Both or neither
                        endcase
                        if (dropped)
                                overflowQ <= 1'b1;
                        else if (doPop)
                                overflowQ <= 1'b0;      // Cleared by reading
                        if (frameErrSet)
                                frameErrQ <= 1'b1;
                end
        end

        assign outData         = mem[rdPtr];            // Show-ahead
        assign status.empty    = (count == '0);
        assign status.halfFull = (count >= halfCount);
        assign status.overflow = overflowQ;
        assign status.frameErr = frameErrQ;

        // Pointer and count bookkeeping must agree over any sequence
        aCountLimit: assert property (@(posedge Data_Rdy) disable iff (Pop_Data)
                count <= fullCount);

endmodule

// File: logic/uartRxTop.sv
// UART 8N1 receive path with a byte FIFO on a valid/ready output
// clksPerBit must be even and at least 4
// fifoDepthLog2 must be at least 2
// rxLine may be asynchronous and cannot be stalled
// Latency from the line depends on its phase and outValid marks arrival
// hold freezes the FIFO and drops bytes that arrive meanwhile

`timescale 1ns/10ps

module uartRxTop #(
        parameter int clksPerBit    = 16,
        parameter int fifoDepthLog2 = 3
) (
        input  logic               Data_Rdy,
        input  logic               Pop_Data,
        input  logic               rxLine,
        input  logic               hold,
        input  logic               outReady,
        output logic               outValid,
        output uartRxPkg::rxByte   outData,
        output uartRxPkg::rxStatus status
);

        logic             timerRun;
        logic             timerRestart;
        logic             midBit;
        logic             shiftEn;
        logic             sampledBit;
        logic             byteValid;
        logic             frameErrSet;
        uartRxPkg::rxByte shiftData;                    // Assembled byte

        ////////////////////
        // Receive datapath
        ////////////////////

        rxBitTimer #(.clksPerBit(clksPerBit)) rxBitTimer_inst (
                .Data_Rdy(Data_Rdy), .Pop_Data(Pop_Data),
                .timerRun(timerRun), .timerRestart(timerRestart),
                .midBit(midBit), .bitEnd());

        rxControl rxControl_inst (
                .Data_Rdy(Data_Rdy), .Pop_Data(Pop_Data),
                .sampledBit(sampledBit), .midBit(midBit),
                .timerRun(timerRun), .timerRestart(timerRestart),
                .shiftEn(shiftEn), .byteValid(byteValid), .frameErrSet(frameErrSet));

        rxShifter rxShifter_inst (
                .Data_Rdy(Data_Rdy), .Pop_Data(Pop_Data),
                .rxLine(rxLine), .shiftEn(shiftEn),
                .sampledBit(sampledBit), .shiftData(shiftData));

        rxFifo #(.fifoDepthLog2(fifoDepthLog2)) rxFifo_inst (
                .Data_Rdy(Data_Rdy), .Pop_Data(Pop_Data),
                .wrValid(byteValid), .wrData(shiftData), .frameErrSet(frameErrSet),
                .hold(hold), .outReady(outReady),
                .outValid(outValid), .outData(outData), .status(status));

endmodule

// File: testbench/uartRxTb.sv
// Directed testbench for the UART receive path
// Runs with 8 clocks per bit and a 4-entry FIFO
// Inputs change on the falling clock edge and outputs are sampled there too
// Each frame is followed by one idle bit time, so its byte is stored on return
// First failed check ends the run

`timescale 1ns/10ps

module uartRxTb;

        localparam int clksPerBit    = 8;
        localparam int fifoDepthLog2 = 2;
        localparam int waitLimit     = 200;             // Cycles before a wait gives up

        logic                      Data_Rdy;
        logic                      Pop_Data;
        logic                      rxLine;
        logic                      hold;
        logic                      outReady;
        logic                      outValid;
        uartRxPkg::rxByte          outData;
        uartRxPkg::rxStatus        status;
        logic [31:0]               lcgState;

        uartRxTop #(.clksPerBit(clksPerBit), .fifoDepthLog2(fifoDepthLog2)) uartRxTop_inst (
                .Data_Rdy(Data_Rdy), .Pop_Data(Pop_Data), .rxLine(rxLine),
                .hold(hold), .outReady(outReady), .outValid(outValid),
                .outData(outData), .status(status));

        always #50 Data_Rdy = ~Data_Rdy;                // 100 ns period

        ////////////////////
        // Helpers
        ////////////////////

        function automatic uartRxPkg::rxByte randByte();
                lcgState = lcgState * 32'd1664525 + 32'd1013904223;
                return lcgState[31:24];                 // Upper bits are the most random
        endfunction

        function automatic uartRxPkg::rxStatus makeStatus(input logic e, input logic h,
                                                          input logic o, input logic f);
                uartRxPkg::rxStatus s;
                s.empty    = e;
                s.halfFull = h;
                s.overflow = o;
                s.frameErr = f;
                return s;
        endfunction

        // One 8N1 frame, LSB first, then a bit time of idle line
        task automatic sendFrame(input uartRxPkg::rxByte value, input logic stopLevel);
                rxLine = 1'b0;                          // Start bit
                repeat (clksPerBit) @(negedge Data_Rdy);
                for (int i = 0; i < 8; i++) begin
                        rxLine = value[i];
                        repeat (clksPerBit) @(negedge Data_Rdy);
                end
                rxLine = stopLevel;
                repeat (clksPerBit) @(negedge Data_Rdy);
                rxLine = 1'b1;                          // Idle gap
                repeat (clksPerBit) @(negedge Data_Rdy);
        endtask

        task automatic checkByte(input string testName, input uartRxPkg::rxByte expected,
                                 input uartRxPkg::rxByte actual);
                if (expected !== actual) begin
                        $display("ERR %s: expected %h, actual %h", testName, expected, actual);
                        $display("STATUS: FAIL");
                        $fatal(1, "Data mismatch");
                end
        endtask

        task automatic checkStatus(input string testName, input uartRxPkg::rxStatus expected,
                                   input uartRxPkg::rxStatus actual);
                if (expected !== actual) begin
                        $display("ERR %s: expected %b, actual %b", testName, expected, actual);
                        $display("STATUS: FAIL");
                        $fatal(1, "Status mismatch");
                end
        endtask

        task automatic checkFlag(input string testName, input logic expected,
                                 input logic actual);
                if (expected !== actual) begin
                        $display("ERR %s: expected %b, actual %b", testName, expected, actual);
                        $display("STATUS: FAIL");
                        $fatal(1, "Flag mismatch");
                end
        endtask

        task automatic waitOutValid(input string testName);
                int cycles;
                cycles = 0;
                while (outValid !== 1'b1 && cycles < waitLimit) begin
                        @(negedge Data_Rdy);
                        cycles++;
                end
                if (outValid !== 1'b1) begin
                        $display("%s: outValid never rose, no byte came out", testName);
                        $display("STATUS: FAIL");
                        $fatal(1, "Timeout");
                end
        endtask

        // Check the head byte, then take it with a one-cycle ready
        task automatic popOne(input string testName, input uartRxPkg::rxByte expected);
                waitOutValid(testName);
                checkByte(testName, expected, outData);
                outReady = 1'b1;
                @(negedge Data_Rdy);
                outReady = 1'b0;
        endtask

        ////////////////////
        // Tests
        ////////////////////

        task automatic singleByte();
                sendFrame(8'hA5, 1'b1);
                waitOutValid("single");
                checkByte("single", 8'hA5, outData);
                checkStatus("single", makeStatus(1'b0, 1'b0, 1'b0, 1'b0), status);
                popOne("single", 8'hA5);
                checkStatus("single empty", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), status);
        endtask

        task automatic orderedBurst();
                uartRxPkg::rxByte sent[$];
                for (int i = 0; i < 3; i++) begin
                        sent.push_back(randByte());
                        sendFrame(sent[i], 1'b1);
                        // halfFull from the second entry on
                        checkStatus("burst fill", makeStatus(1'b0, i >= 1, 1'b0, 1'b0), status);
                end
                for (int i = 0; i < 3; i++)
                        popOne("burst drain", sent[i]);
                checkStatus("burst empty", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), status);
        endtask

        task automatic overflowDrop();
                uartRxPkg::rxByte sent[$];
                for (int i = 0; i < 5; i++) begin
                        sent.push_back(randByte());
                        sendFrame(sent[i], 1'b1);
                end
                checkStatus("overflow full", makeStatus(1'b0, 1'b1, 1'b1, 1'b0), status);
                popOne("overflow pop", sent[0]);
                checkStatus("overflow clear", makeStatus(1'b0, 1'b1, 1'b0, 1'b0), status);
                for (int i = 1; i < 4; i++)
                        popOne("overflow drain", sent[i]);   // Fifth byte never shows
                checkStatus("overflow empty", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), status);
        endtask

        task automatic framingError();
                sendFrame(8'h3C, 1'b0);                 // Low stop bit
                checkStatus("frame bad", makeStatus(1'b1, 1'b0, 1'b0, 1'b1), status);
                sendFrame(8'hC3, 1'b1);
                waitOutValid("frame good");
                checkStatus("frame good", makeStatus(1'b0, 1'b0, 1'b0, 1'b1), status);
                popOne("frame good", 8'hC3);
                checkStatus("frame sticky", makeStatus(1'b1, 1'b0, 1'b0, 1'b1), status);
        endtask

        task automatic holdMode();
                sendFrame(8'h5A, 1'b1);
                waitOutValid("hold first");
                hold = 1'b1;
                @(negedge Data_Rdy);
                checkFlag("hold valid", 1'b0, outValid); // Stored but not offered
                sendFrame(8'h81, 1'b1);                 // Arrives while frozen
                checkFlag("hold valid", 1'b0, outValid);
                checkStatus("hold drop", makeStatus(1'b0, 1'b0, 1'b1, 1'b1), status);
                hold = 1'b0;
                @(negedge Data_Rdy);
                popOne("hold release", 8'h5A);
                checkStatus("hold empty", makeStatus(1'b1, 1'b0, 1'b0, 1'b1), status);
        endtask

        ////////////////////
        // Sequence
        ////////////////////

        initial begin
                Data_Rdy = 1'b0;
                Pop_Data = 1'b1;
                rxLine   = 1'b1;                        // Idle line
                hold     = 1'b0;
                outReady = 1'b0;
                lcgState = 32'hb4658dd6;
                repeat (10) @(posedge Data_Rdy);
                @(negedge Data_Rdy);
                Pop_Data = 1'b0;
                checkStatus("reset", makeStatus(1'b1, 1'b0, 1'b0, 1'b0), status);
                checkFlag("reset valid", 1'b0, outValid);
                singleByte();
                orderedBurst();
                overflowDrop();
                framingError();                         // frameErr stays set from here
                holdMode();
                $display("STATUS: PASS");
                $finish;
        end

endmodule

// File: build.f
logic/uartRxPkg.sv
logic/rxBitTimer.sv
logic/rxControl.sv
logic/rxShifter.sv
logic/rxFifo.sv
logic/uartRxTop.sv
testbench/uartRxTb.sv

// File: Makefile
TOP := uartRxTb

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "^STATUS: PASS$$"

clean:
	rm -rf obj_dir
